// ==== design/mmu_defs.svh ====
// widths, masks and register decode codes for the 11/34 MMU
// the masks reproduce 11/34 behaviour only; PAR holds 12 bits, ACF bit 0 reads as zero
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

`define MMU_VA_W 16
`define MMU_PA_W 22

// register file masks
`define MMU_PAR_RMASK 16'o007777
`define MMU_PDR_RMASK 16'o077716
`define MMU_PDR_WMASK_HI 8'o177
`define MMU_PDR_WMASK_LO 8'o016
`define MMU_MMR3_MASK 16'o000007

// ones placed above a 16-bit I/O page address
`define MMU_IOPAGE_HI 6'o77

// status register select, pxr_addr[1:0] with pxr_addr[7] set
`define MMU_SEL_MMR0 2'b00
`define MMU_SEL_MMR2 2'b10
`define MMU_SEL_MMR3 2'b11

// own register addresses as seen in the virtual I/O page
`define MMU_MMR_VA 16'o177570
`define MMU_MMR3_VA 16'o172516

`endif

// ==== design/mmu_pkg.sv ====
// types shared by the MMU blocks and the testbench
// field layouts follow the KT-11 register formats
`default_nettype none

package mmu_pkg;

   // mode 2'b10 is unused on the 11/34
   typedef enum logic [1:0] {
      MODE_KERNEL = 2'b00,
      MODE_SUPER  = 2'b01,
      MODE_USER   = 2'b11
   } cpu_mode_t;

   typedef struct packed {
      logic       rsvd_15;
      logic [6:0] plf;
      logic       a;
      logic       w;
      logic [1:0] rsvd_5_4;
      logic       ed;
      logic [2:0] acf;
   } pdr_t;

   typedef struct packed {
      logic       nonres;
      logic       ple;
      logic       ro;
      logic       trap_flag;
      logic [2:0] rsvd_11_9;
      logic       maint;
      logic       rsvd_7;
      logic [1:0] mode;
      logic       rsvd_4;
      logic [2:0] page;
      logic       enable;
   } mmr0_t;

   // same layout as pxr_addr[5:0]
   typedef struct packed {
      logic [1:0] mode;
      logic       dspace;
      logic [2:0] apf;
   } pxr_index_t;

endpackage

`default_nettype wire

// ==== design/mmu_fault_if.sv ====
// access check result, all plain combinational levels
`timescale 1ns/1ps
`default_nettype none

interface mmu_fault_if;

   logic abort;
   logic trap;
   logic set_nonres;
   logic set_ple;
   logic set_ro;
   logic set_page;
   logic update_pdr;
   logic set_a;
   logic set_w;

   modport checker_mp (output abort, trap, set_nonres, set_ple, set_ro, set_page,
                       update_pdr, set_a, set_w);
   modport table_mp (input update_pdr, set_a, set_w);
   modport status_mp (input set_nonres, set_ple, set_ro, set_page);

endinterface

`default_nettype wire

// ==== design/page_table.sv ====
// PAR/PDR storage, 64 entries each, split into byte halves
// entries are not cleared by reset and must be written before mapping is on
`timescale 1ns/1ps
`include "mmu_defs.svh"
`default_nettype none

module page_table (
   input  logic                   clk,
   input  logic                   local_reset,
   input  logic                   pxr_wr,
   input  logic                   pxr_rd,
   input  logic [1:0]             pxr_be,
   input  logic [7:0]             pxr_addr,
   input  logic [15:0]            pxr_data_in,
   input  mmu_pkg::pxr_index_t    index,
   mmu_fault_if.table_mp          fault,
   input  logic                   inhibit,
   output mmu_pkg::pdr_t          pdr,
   output logic [15:0]            par,
   output logic [15:0]            table_data
);

   logic [7:0] pdr_h [64];
   logic [7:0] pdr_l [64];
   logic [7:0] par_h [64];
   logic [7:0] par_l [64];

   logic [5:0]    wr_entry;
   logic          table_wr;
   logic          auto_update;
   mmu_pkg::pdr_t pdr_updated;

   assign wr_entry = pxr_addr[5:0];
   assign table_wr = pxr_wr && !pxr_addr[7];

   // entry selected by the current cpu access
   assign pdr = mmu_pkg::pdr_t'({pdr_h[index], pdr_l[index]} & `MMU_PDR_RMASK);
   assign par = {par_h[index], par_l[index]} & `MMU_PAR_RMASK;

   // any register write this cycle wins over the A/W update
   assign auto_update = fault.update_pdr && !pxr_wr && !inhibit && !local_reset;

   always_comb
   begin
      pdr_updated = pdr;
      pdr_updated.a = pdr.a | fault.set_a;
      pdr_updated.w = pdr.w | fault.set_w;
   end

   always_ff @(posedge clk)
   begin
      if (table_wr)
      begin
         if (pxr_addr[6])
         begin
            if (pxr_be[1])
               par_h[wr_entry] <= pxr_data_in[15:8];
            if (pxr_be[0])
               par_l[wr_entry] <= pxr_data_in[7:0];
         end
         else
         begin
            if (pxr_be[1])
               pdr_h[wr_entry] <= pxr_data_in[15:8] & `MMU_PDR_WMASK_HI;
            if (pxr_be[0])
               pdr_l[wr_entry] <= pxr_data_in[7:0] & `MMU_PDR_WMASK_LO;
         end
      end
      else if (auto_update)
      begin
         pdr_h[index] <= pdr_updated[15:8];
         pdr_l[index] <= pdr_updated[7:0];
      end
   end

   // readback through the 11/34 read masks
   always_comb
   begin
      table_data = 16'h0000;
      if (pxr_rd && !pxr_addr[7])
      begin
         if (pxr_addr[6])
            table_data = {par_h[wr_entry], par_l[wr_entry]} & `MMU_PAR_RMASK;
         else
            table_data = {pdr_h[wr_entry], pdr_l[wr_entry]} & `MMU_PDR_RMASK;
      end
   end

endmodule

`default_nettype wire

// ==== design/access_check.sv ====
// 11/34 access control and page length check, purely combinational
// odd ACF codes cannot come out of the PDR read mask and are ignored
`timescale 1ns/1ps
`include "mmu_defs.svh"
`default_nettype none

module access_check (
   input  logic [`MMU_VA_W-1:0] cpu_va,
   input  mmu_pkg::cpu_mode_t   cpu_cm,
   input  logic                 cpu_rd,
   input  logic                 cpu_wr,
   input  logic                 trap_odd,
   input  logic                 mmu_on,
   input  mmu_pkg::pdr_t        pdr,
   mmu_fault_if.checker_mp      fault,
   output logic                 inhibit
);

   logic [6:0] block_num;
   logic       len_err;

   assign block_num = cpu_va[12:6];

   // expand-down pages grow toward lower blocks
   assign len_err = pdr.ed ? (block_num < pdr.plf) : (block_num > pdr.plf);

   // no A/W update when the cpu touches the MMU registers themselves
   assign inhibit = ({cpu_va[15:3], 3'b000} == `MMU_MMR_VA) ||
                    ({cpu_va[15:1], 1'b0} == `MMU_MMR3_VA);

   always_comb
   begin
      fault.abort = 1'b0;
      fault.trap = 1'b0;
      fault.set_nonres = 1'b0;
      fault.set_ple = 1'b0;
      fault.set_ro = 1'b0;
      fault.set_page = 1'b0;
      fault.update_pdr = 1'b0;
      fault.set_a = 1'b0;
      fault.set_w = 1'b0;
      if (mmu_on && (cpu_rd || cpu_wr))
      begin
         if (cpu_cm == mmu_pkg::MODE_SUPER)
         begin
            // no supervisor space on the 11/34
            fault.abort = 1'b1;
            fault.set_nonres = 1'b1;
            fault.set_page = 1'b1;
         end
         else
         begin
            // writes take priority over reads
            case (pdr.acf)
               3'd0:
               begin
                  fault.abort = 1'b1;
                  fault.set_nonres = 1'b1;
                  fault.set_page = 1'b1;
                  fault.set_ple = len_err;
               end
               3'd2:
               begin
                  fault.set_page = 1'b1;
                  fault.set_ple = len_err;
                  fault.set_ro = cpu_wr;
                  fault.abort = cpu_wr || len_err;
               end
               3'd4:
               begin
                  fault.update_pdr = 1'b1;
                  fault.set_a = 1'b1;
                  fault.set_nonres = 1'b1;
                  fault.trap = 1'b1;
               end
               3'd6:
               begin
                  fault.set_page = 1'b1;
                  fault.set_ple = len_err;
                  if (cpu_wr)
                  begin
                     fault.update_pdr = !trap_odd;
                     fault.set_w = !trap_odd;
                     fault.trap = len_err;
                  end
                  else
                     fault.abort = len_err;
               end
               default:
               begin
                  fault.abort = 1'b0;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/address_map.sv ====
// 18-bit mapping only; the top 8 KB of the 18-bit space goes to the 22-bit I/O page
`timescale 1ns/1ps
`include "mmu_defs.svh"
`default_nettype none

module address_map (
   input  logic [`MMU_VA_W-1:0] cpu_va,
   input  logic [15:0]          par,
   input  logic                 map_enable,
   output logic [`MMU_PA_W-1:0] cpu_pa
);

   logic [`MMU_PA_W-1:0] map_sum;
   logic [17:0]          map_18;
   logic                 va_is_iopage;
   logic                 pa_is_iopage;
   logic [`MMU_PA_W-1:0] mapped_pa;
   logic [`MMU_PA_W-1:0] unmapped_pa;

   // PAR counts 64-byte blocks
   assign map_sum = {par, 6'b000000} + {9'b0, cpu_va[12:0]};
   assign map_18 = map_sum[17:0];

   assign va_is_iopage = cpu_va[15:13] == 3'b111;
   assign pa_is_iopage = map_18[17:13] == 5'b11111;

   assign mapped_pa = pa_is_iopage ? {`MMU_IOPAGE_HI, map_18[15:0]} : {4'b0000, map_18};
   assign unmapped_pa = va_is_iopage ? {`MMU_IOPAGE_HI, cpu_va} : {6'b000000, cpu_va};

   assign cpu_pa = map_enable ? mapped_pa : unmapped_pa;

endmodule

`default_nettype wire

// ==== design/mmu_status.sv ====
// MMR0, MMR2 and MMR3; MMR1 is not implemented and reads as zero
// fault capture freezes MMR0 until software clears the error bits
`timescale 1ns/1ps
`include "mmu_defs.svh"
`default_nettype none

module mmu_status (
   input  logic                 clk,
   input  logic                 local_reset,
   input  logic                 pxr_wr,
   input  logic                 pxr_rd,
   input  logic                 fetch_va,
   input  logic                 cpu_d_access,
   input  logic [1:0]           pxr_be,
   input  logic [7:0]           pxr_addr,
   input  logic [15:0]          pxr_data_in,
   input  logic [`MMU_VA_W-1:0] cpu_va,
   input  mmu_pkg::cpu_mode_t   cpu_cm,
   input  logic                 cpu_trap,
   input  logic                 cpu_i_access,
   mmu_fault_if.status_mp       fault,
   output logic                 mmu_on,
   output logic                 map_enable,
   output mmu_pkg::pxr_index_t  index,
   output logic [15:0]          status_data
);

   mmu_pkg::mmr0_t mmr0;
   logic [15:0]    mmr2;
   logic [15:0]    mmr3;
   logic           fault_latched;
   logic           d_space_on;
   logic           mmr_wr;

   assign fault_latched = mmr0.nonres | mmr0.ple | mmr0.ro;
   assign mmu_on = mmr0.enable;
   assign mmr_wr = pxr_wr && pxr_addr[7];

   // maintenance mode maps destination accesses only
   assign map_enable = mmu_on || (mmr0.maint && cpu_d_access);

   always_comb
   begin
      case (cpu_cm)
         mmu_pkg::MODE_KERNEL: d_space_on = mmr3[2];
         mmu_pkg::MODE_SUPER:  d_space_on = mmr3[1];
         mmu_pkg::MODE_USER:   d_space_on = mmr3[0];
         default:              d_space_on = 1'b0;
      endcase
   end

   // trap vector fetches always go through kernel space
   assign index.mode = cpu_trap ? mmu_pkg::MODE_KERNEL : cpu_cm;
   assign index.dspace = d_space_on & ~cpu_i_access;
   assign index.apf = cpu_va[15:13];

   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
      begin
         mmr0 <= '0;
         mmr3 <= 16'h0000;
      end
      else if (pxr_wr)
      begin
         if (mmr_wr && pxr_addr[1:0] == `MMU_SEL_MMR0)
         begin
            if (pxr_be[1])
               mmr0[15:8] <= pxr_data_in[15:8];
            if (pxr_be[0])
               mmr0[7:0] <= pxr_data_in[7:0];
         end
         if (mmr_wr && pxr_addr[1:0] == `MMU_SEL_MMR3)
            mmr3 <= pxr_data_in & `MMU_MMR3_MASK;
      end
      else if (!fault_latched)
      begin
         if (fault.set_nonres)
            mmr0.nonres <= 1'b1;
         if (fault.set_ple)
            mmr0.ple <= 1'b1;
         if (fault.set_ro)
            mmr0.ro <= 1'b1;
         if (fault.set_page)
         begin
            mmr0.mode <= cpu_cm;
            mmr0.page <= cpu_va[15:13];
         end
      end
   end

   // fetch address tracking stops on the first fault
   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
         mmr2 <= 16'h0000;
      else if (fetch_va && !fault_latched && cpu_cm != mmu_pkg::MODE_SUPER)
         mmr2 <= cpu_va;
   end

   always_comb
   begin
      mmu_pkg::mmr0_t live;
      live = mmr0;
      live.mode = cpu_cm;
      live.page = cpu_va[15:13];
      status_data = 16'h0000;
      if (pxr_rd && pxr_addr[7])
      begin
         case (pxr_addr[1:0])
            // latched value after a fault, live mode and page otherwise
            `MMU_SEL_MMR0: status_data = (fault_latched || !mmu_on) ? mmr0 : live;
            `MMU_SEL_MMR2: status_data = mmr2;
            `MMU_SEL_MMR3: status_data = mmr3;
            default:       status_data = 16'h0000;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/mmu_top.sv ====
// KT-11 style MMU, 11/34 behaviour, 18-bit mapping on a 22-bit bus
// PAR/PDR must be loaded before MMR0 enable is set
`timescale 1ns/1ps
`include "mmu_defs.svh"
`default_nettype none

module mmu_top (
   input  logic                 clk,
   input  logic                 local_reset,
   input  logic [`MMU_VA_W-1:0] cpu_va,
   input  mmu_pkg::cpu_mode_t   cpu_cm,
   input  logic                 cpu_rd,
   input  logic                 cpu_wr,
   input  logic                 cpu_i_access,
   input  logic                 cpu_d_access,
   input  logic                 cpu_trap,
   input  logic                 fetch_va,
   input  logic                 trap_odd,
   input  logic                 pxr_wr,
   input  logic                 pxr_rd,
   input  logic [1:0]           pxr_be,
   input  logic [7:0]           pxr_addr,
   input  logic [15:0]          pxr_data_in,
   output logic [`MMU_PA_W-1:0] cpu_pa,
   output logic                 signal_abort,
   output logic                 signal_trap,
   output logic [15:0]          pxr_data_out
);

   mmu_pkg::pdr_t       pdr;
   mmu_pkg::pxr_index_t index;
   logic [15:0]         par;
   logic [15:0]         table_data;
   logic [15:0]         status_data;
   logic                mmu_on;
   logic                map_enable;
   logic                inhibit;

   mmu_fault_if fault_bus ();

   page_table page_table_inst (
      .clk(clk), .local_reset(local_reset),
      .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .pxr_be(pxr_be),
      .pxr_addr(pxr_addr), .pxr_data_in(pxr_data_in),
      .index(index), .fault(fault_bus.table_mp), .inhibit(inhibit),
      .pdr(pdr), .par(par), .table_data(table_data)
   );

   access_check access_check_inst (
      .cpu_va(cpu_va), .cpu_cm(cpu_cm), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
      .trap_odd(trap_odd), .mmu_on(mmu_on), .pdr(pdr),
      .fault(fault_bus.checker_mp), .inhibit(inhibit)
   );

   address_map address_map_inst (
      .cpu_va(cpu_va), .par(par), .map_enable(map_enable), .cpu_pa(cpu_pa)
   );

   mmu_status mmu_status_inst (
      .clk(clk), .local_reset(local_reset),
      .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .fetch_va(fetch_va),
      .cpu_d_access(cpu_d_access), .pxr_be(pxr_be), .pxr_addr(pxr_addr),
      .pxr_data_in(pxr_data_in), .cpu_va(cpu_va), .cpu_cm(cpu_cm),
      .cpu_trap(cpu_trap), .cpu_i_access(cpu_i_access),
      .fault(fault_bus.status_mp), .mmu_on(mmu_on), .map_enable(map_enable),
      .index(index), .status_data(status_data)
   );

   assign signal_abort = fault_bus.abort;
   assign signal_trap = fault_bus.trap;

   // each block drives zero outside its own address range
   assign pxr_data_out = table_data | status_data;

endmodule

`default_nettype wire

// ==== verification/mmu_checker.sv ====
// concurrent checks on the MMU top level, bound into mmu_top
// fail_count is read back by the testbench summary
`timescale 1ns/1ps
`default_nettype none

module mmu_checker (
   input logic               clk,
   input logic               local_reset,
   input logic               mmu_on,
   input mmu_pkg::cpu_mode_t cpu_cm,
   input logic               cpu_rd,
   input logic               cpu_wr,
   input logic               pxr_rd,
   input logic [15:0]        pxr_data_out,
   input logic               signal_abort,
   input logic               signal_trap
);

   int fail_count = 0;

   // MMU off means no fault of any kind
   off_no_fault: assert property (@(posedge clk) disable iff (local_reset)
      !mmu_on |-> (!signal_abort && !signal_trap))
      else
      begin
         fail_count++;
         $error("abort or trap raised while the MMU is off");
      end

   // no supervisor space on the 11/34
   super_aborts: assert property (@(posedge clk) disable iff (local_reset)
      (mmu_on && cpu_cm == mmu_pkg::MODE_SUPER && (cpu_rd || cpu_wr)) |-> signal_abort)
      else
      begin
         fail_count++;
         $error("supervisor access did not abort");
      end

   idle_bus_zero: assert property (@(posedge clk) disable iff (local_reset)
      !pxr_rd |-> (pxr_data_out == 16'h0000))
      else
      begin
         fail_count++;
         $error("register data bus not zero without a read");
      end

   abort_trap_excl: assert property (@(posedge clk) disable iff (local_reset)
      !(signal_abort && signal_trap))
      else
      begin
         fail_count++;
         $error("abort and trap raised together");
      end

endmodule

bind mmu_top mmu_checker checker_inst (
   .clk(clk), .local_reset(local_reset), .mmu_on(mmu_on), .cpu_cm(cpu_cm),
   .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .pxr_rd(pxr_rd), .pxr_data_out(pxr_data_out),
   .signal_abort(signal_abort), .signal_trap(signal_trap)
);

`default_nettype wire

// ==== verification/mmu_tb.sv ====
// directed and LFSR driven tests of the 11/34 MMU
// inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps
`include "mmu_defs.svh"
`default_nettype none

module mmu_tb;

   // tests need about 300 cycles
   localparam int max_cycles = 2000;

   logic               clk;
   logic               local_reset;
   logic [15:0]        cpu_va;
   mmu_pkg::cpu_mode_t cpu_cm;
   logic               cpu_rd;
   logic               cpu_wr;
   logic               cpu_i_access;
   logic               cpu_d_access;
   logic               cpu_trap;
   logic               fetch_va;
   logic               trap_odd;
   logic               pxr_wr;
   logic               pxr_rd;
   logic [1:0]         pxr_be;
   logic [7:0]         pxr_addr;
   logic [15:0]        pxr_data_in;
   logic [21:0]        cpu_pa;
   logic               signal_abort;
   logic               signal_trap;
   logic [15:0]        pxr_data_out;

   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          cycles;
   logic [11:0] par_i [8];
   logic [11:0] par_d [8];
   logic [15:0] rd_data;
   logic [15:0] va;
   logic [15:0] model;
   logic [15:0] data1;
   logic [15:0] data2;
   logic [7:0]  addr;
   logic [1:0]  be;
   logic [15:0] mmr2_hold;

   mmu_top mmu_top_inst (
      .clk(clk), .local_reset(local_reset), .cpu_va(cpu_va), .cpu_cm(cpu_cm),
      .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_i_access(cpu_i_access),
      .cpu_d_access(cpu_d_access), .cpu_trap(cpu_trap), .fetch_va(fetch_va),
      .trap_odd(trap_odd), .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .pxr_be(pxr_be),
      .pxr_addr(pxr_addr), .pxr_data_in(pxr_data_in), .cpu_pa(cpu_pa),
      .signal_abort(signal_abort), .signal_trap(signal_trap), .pxr_data_out(pxr_data_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      logic        fb;
      r = 16'h0000;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[14:0], fb};
      end
      return r;
   endfunction

   function automatic logic [21:0] unmapped_pa(input logic [15:0] v);
      return (v[15:13] == 3'b111) ? {6'h3f, v} : {6'h00, v};
   endfunction

   // 64-byte blocks plus displacement, top 8 KB of 18 bits to the I/O page
   function automatic logic [21:0] mapped_pa(input logic [11:0] p, input logic [15:0] v);
      logic [17:0] s;
      s = {p, 6'b000000} + {5'b00000, v[12:0]};
      return (s[17:13] == 5'h1f) ? {6'h3f, s[15:0]} : {4'h0, s};
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act)
      else
      begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic start_cycle();
      @(posedge clk);
      pxr_wr <= 1'b0;
      pxr_rd <= 1'b0;
      cpu_rd <= 1'b0;
      cpu_wr <= 1'b0;
      fetch_va <= 1'b0;
      trap_odd <= 1'b0;
      cpu_i_access <= 1'b0;
      cpu_d_access <= 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] a, input logic [15:0] d, input logic [1:0] b);
      start_cycle();
      pxr_wr <= 1'b1;
      pxr_addr <= a;
      pxr_data_in <= d;
      pxr_be <= b;
      @(negedge clk);
   endtask

   task automatic reg_read(input logic [7:0] a, output logic [15:0] d);
      start_cycle();
      pxr_rd <= 1'b1;
      pxr_addr <= a;
      @(negedge clk);
      d = pxr_data_out;
   endtask

   task automatic cpu_access(input logic [15:0] v, input mmu_pkg::cpu_mode_t m,
                             input logic wr, input logic i_acc, input logic fetch,
                             input logic odd);
      start_cycle();
      cpu_va <= v;
      cpu_cm <= m;
      cpu_rd <= !wr;
      cpu_wr <= wr;
      cpu_i_access <= i_acc;
      cpu_d_access <= !i_acc;
      fetch_va <= fetch;
      trap_odd <= odd;
      @(negedge clk);
   endtask

   task automatic check_fault(input string name, input logic ab, input logic tr);
      check({name, " abort"}, ab, signal_abort);
      check({name, " trap"}, tr, signal_trap);
   endtask

   initial
   begin
      lfsr = 32'hd1b22e9f;
      errors = 0;
      checks = 0;
      cycles = 0;
      local_reset = 1'b1;
      cpu_va = 16'h0000;
      cpu_cm = mmu_pkg::MODE_KERNEL;
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
      cpu_i_access = 1'b0;
      cpu_d_access = 1'b0;
      cpu_trap = 1'b0;
      fetch_va = 1'b0;
      trap_odd = 1'b0;
      pxr_wr = 1'b0;
      pxr_rd = 1'b0;
      pxr_be = 2'b00;
      pxr_addr = 8'h00;
      pxr_data_in = 16'h0000;
      repeat (4) @(posedge clk);
      local_reset <= 1'b0;

      // MMU off after reset
      for (int i = 0; i < 8; i++)
      begin
         va = rand_bits(16);
         cpu_access(va, mmu_pkg::MODE_KERNEL, 1'(rand_bits(1)), 1'b1, 1'b0, 1'b0);
         check("unmapped pa", unmapped_pa(va), cpu_pa);
         check_fault("unmapped", 1'b0, 1'b0);
      end

      // table writes through byte enables and masks
      for (int i = 0; i < 12; i++)
      begin
         addr = 8'(rand_bits(7));
         data1 = rand_bits(16);
         data2 = rand_bits(16);
         be = 2'(rand_bits(2));
         reg_write(addr, data1, 2'b11);
         reg_write(addr, data2, be);
         if (addr[6])
            model = data1;
         else
            model = {data1[15:8] & `MMU_PDR_WMASK_HI, data1[7:0] & `MMU_PDR_WMASK_LO};
         if (be[1])
            model[15:8] = addr[6] ? data2[15:8] : data2[15:8] & `MMU_PDR_WMASK_HI;
         if (be[0])
            model[7:0] = addr[6] ? data2[7:0] : data2[7:0] & `MMU_PDR_WMASK_LO;
         model = model & (addr[6] ? `MMU_PAR_RMASK : `MMU_PDR_RMASK);
         reg_read(addr, rd_data);
         check("table readback", model, rd_data);
      end
      data1 = rand_bits(16);
      reg_write(8'h83, data1, 2'b11);
      reg_read(8'h83, rd_data);
      check("mmr3 readback", data1 & `MMU_MMR3_MASK, rd_data);
      reg_read(8'h81, rd_data);
      check("unused mmr", 16'h0000, rd_data);

      // kernel I and D pages, full length, read/write
      reg_write(8'h83, 16'h0000, 2'b11);
      for (int p = 0; p < 8; p++)
      begin
         par_i[p] = 12'(rand_bits(12));
         par_d[p] = 12'(rand_bits(12));
      end
      par_i[1] = 12'o7600;
      for (int p = 0; p < 8; p++)
      begin
         reg_write(8'h40 | p[7:0], {4'h0, par_i[p]}, 2'b11);
         reg_write(8'h48 | p[7:0], {4'h0, par_d[p]}, 2'b11);
         reg_write(8'h00 | p[7:0], 16'h7f06, 2'b11);
         reg_write(8'h08 | p[7:0], 16'h7f06, 2'b11);
      end
      reg_write(8'h80, 16'h0001, 2'b11);
      for (int p = 0; p < 8; p++)
      begin
         va = {p[2:0], 13'h0000} | rand_bits(13);
         cpu_access(va, mmu_pkg::MODE_KERNEL, 1'b0, 1'b1, 1'b0, 1'b0);
         check("mapped i pa", mapped_pa(par_i[p], va), cpu_pa);
         check_fault("mapped i", 1'b0, 1'b0);
      end
      reg_write(8'h83, 16'h0004, 2'b11);
      for (int p = 0; p < 8; p++)
      begin
         va = {p[2:0], 13'h0000} | rand_bits(13);
         cpu_access(va, mmu_pkg::MODE_KERNEL, 1'b0, 1'b0, 1'b0, 1'b0);
         check("mapped d pa", mapped_pa(par_d[p], va), cpu_pa);
         cpu_access(va, mmu_pkg::MODE_KERNEL, 1'b0, 1'b1, 1'b0, 1'b0);
         check("mapped i with mmr3", mapped_pa(par_i[p], va), cpu_pa);
      end

      // user pages: apf2 ACF 0, apf3 ACF 2, apf4 ACF 4, apf5/6 ACF 6
      reg_write(8'h32, 16'h7f00, 2'b11);
      reg_write(8'h33, 16'h7f02, 2'b11);
      reg_write(8'h34, 16'h7f04, 2'b11);
      reg_write(8'h35, 16'h7f06, 2'b11);
      reg_write(8'h36, 16'h7f06, 2'b11);
      cpu_access(16'h4010, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("acf0 read", 1'b1, 1'b0);
      reg_read(8'h80, rd_data);
      check("mmr0 nonres", 16'h8065, rd_data);
      cpu_access(16'h6020, mmu_pkg::MODE_USER, 1'b1, 1'b0, 1'b0, 1'b0);
      check_fault("acf2 write frozen", 1'b1, 1'b0);
      cpu_access(16'ha000, mmu_pkg::MODE_SUPER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("super frozen", 1'b1, 1'b0);
      reg_read(8'h80, rd_data);
      check("mmr0 frozen", 16'h8065, rd_data);
      reg_write(8'h80, 16'h0001, 2'b11);
      cpu_access(16'h6020, mmu_pkg::MODE_USER, 1'b1, 1'b0, 1'b0, 1'b0);
      check_fault("acf2 write", 1'b1, 1'b0);
      reg_read(8'h80, rd_data);
      check("mmr0 ro", 16'h2067, rd_data);
      reg_write(8'h80, 16'h0001, 2'b11);
      cpu_access(16'ha000, mmu_pkg::MODE_SUPER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("super read", 1'b1, 1'b0);
      reg_read(8'h80, rd_data);
      check("mmr0 super", 16'h802b, rd_data);

      // traps and A/W updates
      cpu_access(16'h8040, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("acf4 read", 1'b0, 1'b1);
      reg_read(8'h34, rd_data);
      check("acf4 a bit", 16'h7f84, rd_data);
      cpu_access(16'ha040, mmu_pkg::MODE_USER, 1'b1, 1'b0, 1'b0, 1'b0);
      check_fault("acf6 write", 1'b0, 1'b0);
      reg_read(8'h35, rd_data);
      check("acf6 w bit", 16'h7f46, rd_data);
      cpu_access(16'hc040, mmu_pkg::MODE_USER, 1'b1, 1'b0, 1'b0, 1'b1);
      check_fault("acf6 write odd", 1'b0, 1'b0);
      reg_read(8'h36, rd_data);
      check("acf6 no w bit", 16'h7f06, rd_data);

      // length errors on apf7, length 3 upward then downward
      reg_write(8'h37, 16'h0306, 2'b11);
      cpu_access(16'he280, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("len read up", 1'b1, 1'b0);
      cpu_access(16'he280, mmu_pkg::MODE_USER, 1'b1, 1'b0, 1'b0, 1'b0);
      check_fault("len write up", 1'b0, 1'b1);
      cpu_access(16'he080, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("in range up", 1'b0, 1'b0);
      reg_write(8'h37, 16'h030e, 2'b11);
      cpu_access(16'he080, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("len read down", 1'b1, 1'b0);
      cpu_access(16'he080, mmu_pkg::MODE_USER, 1'b1, 1'b0, 1'b0, 1'b0);
      check_fault("len write down", 1'b0, 1'b1);
      cpu_access(16'he280, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      check_fault("in range down", 1'b0, 1'b0);

      // MMR2 follows fetches until a fault
      reg_write(8'h80, 16'h0001, 2'b11);
      for (int i = 0; i < 3; i++)
      begin
         va = rand_bits(13);
         cpu_access(va, mmu_pkg::MODE_KERNEL, 1'b0, 1'b1, 1'b1, 1'b0);
         reg_read(8'h82, rd_data);
         check("mmr2 track", va, rd_data);
      end
      mmr2_hold = va;
      cpu_access(16'h4000, mmu_pkg::MODE_USER, 1'b0, 1'b0, 1'b0, 1'b0);
      cpu_access(16'h2468, mmu_pkg::MODE_KERNEL, 1'b0, 1'b1, 1'b1, 1'b0);
      reg_read(8'h82, rd_data);
      check("mmr2 hold", mmr2_hold, rd_data);

      start_cycle();
      @(negedge clk);
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, mmu_top_inst.checker_inst.fail_count);
      if (errors == 0 && mmu_top_inst.checker_inst.fail_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/mmu_pkg.sv
design/mmu_fault_if.sv
design/page_table.sv
design/access_check.sv
design/address_map.sv
design/mmu_status.sv
design/mmu_top.sv
verification/mmu_checker.sv
verification/mmu_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mmu_tb -o mmu_sim

./obj_dir/mmu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
   exit 0
else
   exit 1
fi
